// File: src/ec_pkg.sv
package ec_pkg;

    localparam int range_bits = 16;
    localparam int low_bits   = 24;
    localparam int sym_bits   = 4;
    localparam int shift_bits = 5;

    typedef logic [range_bits-1:0] range_t;
    typedef logic [low_bits-1:0]   low_t;
    typedef logic [range_bits:0]   wide_t;
    typedef logic [sym_bits-1:0]   sym_t;
    typedef logic [sym_bits:0]     nsyms_t;
    typedef logic [shift_bits-1:0] shift_t;
    typedef logic [15:0]           ec_word_t;
    typedef logic [1:0]            word_flag_t;

    localparam range_t range_init = 16'h8000;

    // which low update the event needs in stage 3
    typedef enum logic [1:0] {
        mode_first  = 2'd0,
        mode_mid    = 2'd1,
        mode_bool_0 = 2'd2,
        mode_bool_1 = 2'd3
    } ec_mode_t;

    typedef struct packed {
        range_t fl;
        range_t fh;
        sym_t   symbol;
        nsyms_t nsyms;
        logic   is_bool;
    } ec_event_t;

    typedef struct packed {
        range_t fl_scaled;
        range_t fh_scaled;
        range_t term_u;
        range_t term_v;
        logic   fl_low;
        logic   is_bool;
        logic   bool_bit;
    } s1_to_s2_t;

    typedef struct packed {
        range_t   r;
        wide_t    u;
        wide_t    v;
        shift_t   d;
        ec_mode_t mode;
    } s2_to_s3_t;

    typedef struct packed {
        range_t     range;
        low_t       low;
        range_t     offs;
        word_flag_t flag;
        ec_word_t   word_1;
        ec_word_t   word_2;
    } ec_out_t;

    // range before normalization, shared by stage 2 and stage 3
    function automatic range_t ec_new_range(input s2_to_s3_t x);
        case (x.mode)
            mode_mid:    return range_t'(x.u - x.v);
            mode_bool_1: return range_t'(x.v);
            default:     return range_t'(wide_t'(x.r) - x.v);
        endcase
    endfunction

endpackage

// File: src/ec_control.sv
`timescale 1ns/1ps

module ec_control (
    input  logic general_clk,
    input  logic reset,
    input  logic in_valid,
    output logic en_1_2,
    output logic en_2_3,
    output logic en_final,
    output logic out_valid
);

    // one valid bit per register stage
    logic [2:0] valid_q;

    always_ff @(posedge general_clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[1:0], in_valid};
        end
    end

    assign en_1_2    = in_valid;
    assign en_2_3    = valid_q[0];
    assign en_final  = valid_q[1];
    assign out_valid = valid_q[2];

    // ------------------------------------------------------------------------
    // checks

    // final registers only load behind an event that went through stage 2
    a_final_follows_s2: assert property (
        @(posedge general_clk) disable iff (reset)
        en_final |-> $past(en_2_3)
    );

endmodule

// File: src/ec_stage_1.sv
`timescale 1ns/1ps

module ec_stage_1 import ec_pkg::*; #(
    parameter int min_prob = 4
) (
    input  ec_event_t ev,
    output s1_to_s2_t s1
);

    localparam int table_size = 2 ** $bits(nsyms_t);

    // multiples of min_prob, one per possible n - symbol value
    range_t min_table [table_size];

    for (genvar i = 0; i < table_size; i++) begin : g_min_table
        assign min_table[i] = range_t'(min_prob * i);
    end

    nsyms_t n_minus_sym;
    nsyms_t idx_u;
    nsyms_t idx_v;

    // n = nsyms - 1
    assign n_minus_sym = ev.nsyms - nsyms_t'(1) - nsyms_t'(ev.symbol);
    assign idx_u       = n_minus_sym + nsyms_t'(1);

    // bool mode always adds a single min_prob
    assign idx_v = ev.is_bool ? nsyms_t'(1) : n_minus_sym;

    always_comb begin
        s1.fl_scaled = ev.fl >> 6;
        s1.fh_scaled = ev.fh >> 6;
        s1.term_u    = min_table[idx_u];
        s1.term_v    = min_table[idx_v];
        s1.fl_low    = ~ev.fl[15];
        s1.is_bool   = ev.is_bool;
        s1.bool_bit  = ev.symbol[0];
    end

endmodule

// File: src/ec_normalize.sv
`timescale 1ns/1ps

module ec_normalize import ec_pkg::*; (
    input  range_t range_in,
    output range_t range_out,
    output shift_t d
);

    // leading zeros, highest set bit wins
    always_comb begin
        d = shift_t'(range_bits);
        for (int i = 0; i < range_bits; i++) begin
            if (range_in[i]) begin
                d = shift_t'(range_bits - 1 - i);
            end
        end
    end

    assign range_out = range_in << d;

endmodule

// File: src/ec_stage_2.sv
`timescale 1ns/1ps

module ec_stage_2 import ec_pkg::*; (
    input  logic      general_clk,
    input  logic      reset,
    input  logic      en,
    input  s1_to_s2_t s1,
    output s2_to_s3_t s2
);

    range_t range_q;
    range_t range_norm;
    range_t range_raw;
    shift_t d;

    logic [17:0] prod_u;
    logic [17:0] prod_v;
    wide_t       u;
    wide_t       v;
    ec_mode_t    mode;

    // ------------------------------------------------------------------------
    // range multiply

    assign prod_u = 18'(range_q[15:8]) * 18'(s1.fl_scaled[9:0]);
    assign prod_v = 18'(range_q[15:8]) * 18'(s1.fh_scaled[9:0]);

    assign u = wide_t'(prod_u >> 1) + wide_t'(s1.term_u);
    assign v = wide_t'(prod_v >> 1) + wide_t'(s1.term_v);

    always_comb begin
        if (s1.is_bool) begin
            mode = s1.bool_bit ? mode_bool_1 : mode_bool_0;
        end else if (s1.fl_low) begin
            mode = mode_mid;
        end else begin
            mode = mode_first;
        end
    end

    always_comb begin
        s2.r    = range_q;
        s2.u    = u;
        s2.v    = v;
        s2.d    = d;
        s2.mode = mode;
    end

    // ------------------------------------------------------------------------
    // new range and normalization

    assign range_raw = ec_new_range('{r: range_q, u: u, v: v, d: '0, mode: mode});

    ec_normalize u_normalize (
        .range_in  (range_raw),
        .range_out (range_norm),
        .d         (d)
    );

    // closes the range loop for the next event
    always_ff @(posedge general_clk) begin
        if (reset) begin
            range_q <= range_init;
        end else if (en) begin
            range_q <= range_norm;
        end
    end

    a_range_normalized: assert property (
        @(posedge general_clk) disable iff (reset)
        range_q[15]
    );

endmodule

// File: src/ec_stage_3.sv
`timescale 1ns/1ps

module ec_stage_3 import ec_pkg::*; (
    input  logic      general_clk,
    input  logic      reset,
    input  logic      en,
    input  s2_to_s3_t s2,
    output ec_out_t   result
);

    range_t     range_q;
    low_t       low_q;
    shift_t     s_q;
    range_t     offs_q;
    word_flag_t flag_q;
    ec_word_t   word_1_q;
    ec_word_t   word_2_q;

    low_t       low_incr;
    low_t       low_sum;
    logic [5:0] s_plus_d;
    shift_t     c_first;
    shift_t     c_second;
    low_t       low_a;
    low_t       low_b;
    low_t       low_kept;
    shift_t     s_next;
    word_flag_t flag_next;
    ec_word_t   word_1_next;
    ec_word_t   word_2_next;

    // ------------------------------------------------------------------------
    // low update

    always_comb begin
        case (s2.mode)
            mode_mid:    low_incr = low_t'(s2.r) - low_t'(s2.u);
            mode_bool_1: low_incr = low_t'(s2.r) - low_t'(s2.v);
            default:     low_incr = '0;
        endcase
    end

    assign low_sum = low_q + low_incr;

    // ------------------------------------------------------------------------
    // word emission, s holds the bit count plus 9

    assign s_plus_d = {1'b0, s_q} + {1'b0, s2.d};
    assign c_first  = s_q + shift_t'(7);
    assign c_second = c_first - shift_t'(8);
    assign low_a    = low_sum & ~(low_t'('1) << c_first);
    assign low_b    = low_a & ~(low_t'('1) << c_second);

    always_comb begin
        word_1_next = '0;
        word_2_next = '0;
        if (s_plus_d >= 6'd17) begin
            flag_next   = 2'd2;
            word_1_next = ec_word_t'(low_sum >> c_first);
            word_2_next = ec_word_t'(low_a >> c_second);
            low_kept    = low_b;
            s_next      = shift_t'(s_plus_d - 6'd16);
        end else if (s_plus_d >= 6'd9) begin
            flag_next   = 2'd1;
            word_1_next = ec_word_t'(low_sum >> c_first);
            low_kept    = low_a;
            s_next      = shift_t'(s_plus_d - 6'd8);
        end else begin
            flag_next = 2'd0;
            low_kept  = low_sum;
            s_next    = shift_t'(s_plus_d);
        end
    end

    always_ff @(posedge general_clk) begin
        if (reset) begin
            range_q  <= range_init;
            low_q    <= '0;
            s_q      <= '0;
            offs_q   <= '0;
            flag_q   <= '0;
            word_1_q <= '0;
            word_2_q <= '0;
        end else if (en) begin
            range_q  <= ec_new_range(s2) << s2.d;
            low_q    <= low_kept << s2.d;
            s_q      <= s_next;
            offs_q   <= offs_q + range_t'(flag_next);
            flag_q   <= flag_next;
            word_1_q <= word_1_next;
            word_2_q <= word_2_next;
        end
    end

    always_comb begin
        result.range  = range_q;
        result.low    = low_q;
        result.offs   = offs_q;
        result.flag   = flag_q;
        result.word_1 = word_1_q;
        result.word_2 = word_2_q;
    end

    a_flag_range: assert property (
        @(posedge general_clk) disable iff (reset)
        flag_q != 2'd3
    );

endmodule

// File: src/arithmetic_encoder.sv
`timescale 1ns/1ps

module arithmetic_encoder import ec_pkg::*; #(
    parameter int min_prob = 4
) (
    input  logic      general_clk,
    input  logic      reset,
    input  logic      in_valid,
    input  ec_event_t ev,
    output ec_out_t   result,
    output logic      out_valid
);

    logic en_1_2;
    logic en_2_3;
    logic en_final;

    s1_to_s2_t s1;
    s1_to_s2_t s1_q;
    s2_to_s3_t s2;
    s2_to_s3_t s2_q;

    ec_control u_control (
        .general_clk (general_clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .en_1_2      (en_1_2),
        .en_2_3      (en_2_3),
        .en_final    (en_final),
        .out_valid   (out_valid)
    );

    // ------------------------------------------------------------------------
    // stage 1

    ec_stage_1 #(
        .min_prob (min_prob)
    ) u_stage_1 (
        .ev (ev),
        .s1 (s1)
    );

    always_ff @(posedge general_clk) begin
        if (en_1_2) begin
            s1_q <= s1;
        end
    end

    // ------------------------------------------------------------------------
    // stage 2

    ec_stage_2 u_stage_2 (
        .general_clk (general_clk),
        .reset       (reset),
        .en          (en_2_3),
        .s1          (s1_q),
        .s2          (s2)
    );

    always_ff @(posedge general_clk) begin
        if (en_2_3) begin
            s2_q <= s2;
        end
    end

    // ------------------------------------------------------------------------
    // stage 3 holds the final state registers

    ec_stage_3 u_stage_3 (
        .general_clk (general_clk),
        .reset       (reset),
        .en          (en_final),
        .s2          (s2_q),
        .result      (result)
    );

endmodule

// File: tests/tb_ec_model.svh
`ifndef TB_EC_MODEL_SVH
`define TB_EC_MODEL_SVH

// encoder state, cnt is the true bit count and starts at -9
int      m_range;
int      m_low;
int      m_cnt;
int      m_offs;
ec_out_t exp_q[$];

task automatic reset_model();
    m_range = 32768;
    m_low   = 0;
    m_cnt   = -9;
    m_offs  = 0;
    exp_q.delete();
endtask

task automatic encode_event(input ec_event_t e, input int min_p);
    int      r8;
    int      n;
    int      sym;
    int      u;
    int      v;
    int      rng;
    int      d;
    int      c;
    int      s;
    int      nwords;
    ec_out_t o;
    r8     = m_range >> 8;
    n      = int'(e.nsyms) - 1;
    sym    = int'(e.symbol);
    nwords = 0;
    o      = '0;
    if (e.is_bool) begin
        v = ((r8 * int'(e.fh >> 6)) >> 1) + min_p;
        if (e.symbol[0]) begin
            m_low = m_low + m_range - v;
            rng   = v;
        end else begin
            rng = m_range - v;
        end
    end else begin
        v = ((r8 * int'(e.fh >> 6)) >> 1) + min_p * (n - sym);
        if (int'(e.fl) < 32768) begin
            u     = ((r8 * int'(e.fl >> 6)) >> 1) + min_p * (n - sym + 1);
            m_low = m_low + m_range - u;
            rng   = u - v;
        end else begin
            rng = m_range - v;
        end
    end
    m_low = m_low & 32'h00ff_ffff;
    d = 0;
    while (d < 16 && ((rng << d) & 32'h0000_8000) == 0) begin
        d++;
    end
    // ------------------------------------------------------------------------
    // pre-carry words
    c = m_cnt;
    s = c + d;
    if (s >= 0) begin
        c = c + 16;
        if (s >= 8) begin
            o.word_1 = ec_word_t'(m_low >> c);
            m_low    = m_low & ((1 << c) - 1);
            c        = c - 8;
            nwords   = 1;
        end
        if (nwords == 0) begin
            o.word_1 = ec_word_t'(m_low >> c);
        end else begin
            o.word_2 = ec_word_t'(m_low >> c);
        end
        nwords++;
        m_low = m_low & ((1 << c) - 1);
        s     = c + d - 24;
    end
    m_cnt   = s;
    m_low   = (m_low << d) & 32'h00ff_ffff;
    m_range = (rng << d) & 32'h0000_ffff;
    m_offs  = m_offs + nwords;
    o.range = range_t'(m_range);
    o.low   = low_t'(m_low);
    o.offs  = range_t'(m_offs);
    o.flag  = word_flag_t'(nwords);
    exp_q.push_back(o);
endtask

`endif

// File: tests/tb_arithmetic_encoder.sv
`timescale 1ns/1ps

module tb_arithmetic_encoder import ec_pkg::*; ();

    localparam int min_prob = 4;
    localparam int n_events = 24;
    localparam int max_wait = 20;
    localparam int latency  = 3;

    logic      general_clk;
    logic      reset;
    logic      in_valid;
    ec_event_t ev;
    ec_out_t   result;
    logic      out_valid;

    int        cycle = 0;
    int        pass_num;
    int        n_checked;
    int        sent_cycle_q[$];
    ec_out_t   last_result;

    `include "tb_ec_model.svh"

    // fl, fh, symbol, nsyms, is_bool
    ec_event_t stim [n_events] = '{
        '{16'd32768, 16'd20000, 4'd0,  5'd4,  1'b0},
        '{16'd20000, 16'd12000, 4'd1,  5'd4,  1'b0},
        '{16'd12000, 16'd4000,  4'd2,  5'd4,  1'b0},
        '{16'd4000,  16'd0,     4'd3,  5'd4,  1'b0},
        '{16'd0,     16'd16384, 4'd1,  5'd2,  1'b1},
        '{16'd0,     16'd16384, 4'd0,  5'd2,  1'b1},
        '{16'd32768, 16'd8192,  4'd0,  5'd2,  1'b0},
        '{16'd8192,  16'd0,     4'd1,  5'd2,  1'b0},
        '{16'd128,   16'd0,     4'd15, 5'd16, 1'b0},
        '{16'd64,    16'd0,     4'd7,  5'd8,  1'b0},
        '{16'd32767, 16'd32704, 4'd1,  5'd16, 1'b0},
        '{16'd32768, 16'd32700, 4'd0,  5'd2,  1'b0},
        '{16'd0,     16'd64,    4'd1,  5'd2,  1'b1},
        '{16'd0,     16'd32704, 4'd0,  5'd2,  1'b1},
        '{16'd0,     16'd30000, 4'd1,  5'd2,  1'b1},
        '{16'd0,     16'd2000,  4'd0,  5'd2,  1'b1},
        '{16'd30000, 16'd25000, 4'd3,  5'd8,  1'b0},
        '{16'd32768, 16'd31000, 4'd0,  5'd8,  1'b0},
        '{16'd1000,  16'd200,   4'd9,  5'd12, 1'b0},
        '{16'd32767, 16'd32704, 4'd1,  5'd16, 1'b0},
        '{16'd64,    16'd0,     4'd15, 5'd16, 1'b0},
        '{16'd0,     16'd24000, 4'd0,  5'd2,  1'b1},
        '{16'd16000, 16'd15000, 4'd5,  5'd10, 1'b0},
        '{16'd32768, 16'd100,   4'd0,  5'd3,  1'b0}
    };

    arithmetic_encoder #(
        .min_prob (min_prob)
    ) u_dut (
        .general_clk (general_clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .ev          (ev),
        .result      (result),
        .out_valid   (out_valid)
    );

    initial begin
        general_clk = 1'b0;
        forever #5 general_clk = ~general_clk;
    end

    always @(posedge general_clk) begin
        cycle <= cycle + 1;
    end

    // ------------------------------------------------------------------------
    // checks

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_range(input string name, input range_t exp, input range_t act);
        if (act !== exp) begin
            stop_run($sformatf("Mismatch %s range: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_low(input string name, input low_t exp, input low_t act);
        if (act !== exp) begin
            stop_run($sformatf("Mismatch %s low: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input word_flag_t exp, input word_flag_t act);
        if (act !== exp) begin
            stop_run($sformatf("Mismatch %s flag: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input ec_word_t exp, input ec_word_t act);
        if (act !== exp) begin
            stop_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_offs(input string name, input range_t exp, input range_t act);
        if (act !== exp) begin
            stop_run($sformatf("Mismatch %s offs: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic compare_result(input string name, input ec_out_t exp, input ec_out_t act);
        check_range(name, exp.range, act.range);
        check_low(name, exp.low, act.low);
        check_flag(name, exp.flag, act.flag);
        if (exp.flag != 2'd0) begin
            check_word({name, " word_1"}, exp.word_1, act.word_1);
        end
        if (exp.flag == 2'd2) begin
            check_word({name, " word_2"}, exp.word_2, act.word_2);
        end
        check_offs(name, exp.offs, act.offs);
    endtask

    // outputs sampled on the falling edge half a cycle after they change
    always @(negedge general_clk) begin : sample_outputs
        string name;
        if (!reset) begin
            if (in_valid) begin
                sent_cycle_q.push_back(cycle);
            end
            if (out_valid) begin
                name = $sformatf("pass %0d event %0d", pass_num, n_checked);
                if (exp_q.size() == 0) begin
                    stop_run("out_valid went high with no event in flight");
                end
                if (cycle - sent_cycle_q[0] != latency) begin
                    stop_run($sformatf("%s came out %0d cycles after its input",
                        name, cycle - sent_cycle_q[0]));
                end
                compare_result(name, exp_q[0], result);
                last_result = exp_q.pop_front();
                void'(sent_cycle_q.pop_front());
                n_checked++;
            end else begin
                // a bubble must leave the state alone
                compare_result("idle hold", last_result, result);
            end
        end
    end

    // ------------------------------------------------------------------------
    // sequencing

    task automatic apply_reset();
        reset    <= 1'b1;
        in_valid <= 1'b0;
        repeat (3) @(posedge general_clk);
        reset <= 1'b0;
        reset_model();
        sent_cycle_q.delete();
        last_result       = '0;
        last_result.range = 16'd32768;
        @(negedge general_clk);
        if (out_valid !== 1'b0) begin
            stop_run("out_valid is high right after reset");
        end
        compare_result("after reset", last_result, result);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == max_wait) begin
                stop_run("timed out waiting for out_valid");
            end
            @(posedge general_clk);
            waited++;
        end
        repeat (3) @(posedge general_clk);
    endtask

    initial begin
        int idle;
        void'($urandom(40634));
        reset    <= 1'b1;
        in_valid <= 1'b0;
        ev       <= '0;
        // pass 0 back to back and pass 1 with random bubbles
        for (int p = 0; p < 2; p++) begin
            pass_num  = p;
            n_checked = 0;
            apply_reset();
            for (int i = 0; i < n_events; i++) begin
                @(posedge general_clk);
                ev       <= stim[i];
                in_valid <= 1'b1;
                encode_event(stim[i], min_prob);
                idle = (p == 0) ? 0 : int'($urandom % 3);
                for (int k = 0; k < idle; k++) begin
                    @(posedge general_clk);
                    in_valid <= 1'b0;
                end
            end
            @(posedge general_clk);
            in_valid <= 1'b0;
            wait_drain();
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+tests
src/ec_pkg.sv
src/ec_control.sv
src/ec_stage_1.sv
src/ec_normalize.sv
src/ec_stage_2.sv
src/ec_stage_3.sv
src/arithmetic_encoder.sv
tests/tb_arithmetic_encoder.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, then look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_arithmetic_encoder -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "simulation did not complete" >&2

grep -q "All checks passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
